//--- compile.f
source/rx_pkg.sv
source/adc_unfold.sv
source/pi_ctl_scaler.sv
source/bit_slicer.sv
source/prbs_generator.sv
source/prbs_checker.sv
source/rx_core.sv
test/rx_core_checker.sv
test/tb_rx_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rx_core
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/100ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/tb_rx_core.sv
module tb_rx_core;

    timeunit 1ns;
    timeprecision 100ps;

    import rx_pkg::*;

    // reset, idle, adc/pi random, bist loop, adc loop, plus margin
    localparam int max_cycles = 10 + 20 + 200 + 300 + 200 + 200;
    localparam logic [NPRBS-1:0] eqn = 32'h8020_0003;

    logic                   clk_adc;
    logic                   rst_i;
    logic [NADC-1:0]        adc_mag_i [NTI];
    logic [NTI-1:0]         adc_sign_i;
    logic signed [NADC-1:0] pfd_offset_i [NTI];
    logic [NPI-1:0]         pi_ctl_i [NOUT];
    logic [NPI-1:0]         pi_ctl_offset_i [NOUT];
    logic [MAX_SEL_W-1:0]   max_sel_i [NOUT];
    logic [NOUT-1:0]        en_bypass_pi_i;
    logic [NPI-1:0]         bypass_pi_i [NOUT];
    logic signed [NADC-1:0] slice_thresh_i;
    rx_src_e                sel_src_i;
    logic                   prbs_gen_cke_i;
    logic [NPRBS-1:0]       prbs_gen_init_i;
    logic [NPRBS-1:0]       prbs_gen_eqn_i;
    logic                   prbs_gen_inj_err_i;
    logic                   prbs_cke_i;
    logic [NPRBS-1:0]       prbs_eqn_i;
    logic [NTI-1:0]         prbs_chan_sel_i;
    logic [NTI-1:0]         prbs_inv_i;
    chk_mode_e              prbs_mode_i;
    logic signed [NADC-1:0] adc_code_o [NTI];
    logic [NPI-1:0]         pi_ctl_o [NOUT];
    logic [CNT_W-1:0]       prbs_err_bits_o;
    logic [CNT_W-1:0]       prbs_total_bits_o;

    logic [31:0]      seed = 32'h1f77;
    logic [NPRBS-1:0] tx_state = 32'h0000_ace1;
    int               cycles = 0;

    rx_core u_rx_core (.*);

    bind rx_core rx_core_checker u_checker (.*);

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic next_cycle();
        @(posedge clk_adc);
        #2;
    endtask

    task automatic drive_random_adc_pi();
        logic [31:0] r;
        for (int k = 0; k < NTI; k++) begin
            r = lcg_next();
            adc_mag_i[k]    = r[31:24];
            adc_sign_i[k]   = r[8];
            pfd_offset_i[k] = r[23:16];
        end
        for (int j = 0; j < NOUT; j++) begin
            r = lcg_next();
            pi_ctl_i[j]        = r[31:23];
            pi_ctl_offset_i[j] = r[22:14];
            max_sel_i[j]       = r[13:9];
            bypass_pi_i[j]     = r[8:0];
            en_bypass_pi_i[j]  = (r[3:0] == 4'h0);
        end
        // random threshold, generator steps only now and then
        r = lcg_next();
        slice_thresh_i = r[31:24];
        prbs_gen_cke_i = r[4];
    endtask

    // one sign bit from the local pattern, inverted where the checker flips it back
    task automatic drive_adc_pattern(input int flip_slice);
        logic b;
        b = ^(tx_state & eqn);
        tx_state = {tx_state[NPRBS-2:0], b};
        adc_sign_i = {NTI{b}} ^ prbs_inv_i;
        if (flip_slice >= 0) begin
            adc_sign_i[flip_slice] = ~adc_sign_i[flip_slice];
        end
    endtask

    initial begin
        clk_adc = 1'b0;
        forever #20 clk_adc = ~clk_adc;
    end

    always @(posedge clk_adc) begin
        cycles <= cycles + 1;
        if (u_rx_core.u_checker.fail_cnt != 0) begin
            $display("FAIL: see errors above");
            $fatal(1, "assertion failure in the rx core checker");
        end else if (cycles >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] r;
        for (int k = 0; k < NTI; k++) begin
            adc_mag_i[k]    = '0;
            pfd_offset_i[k] = '0;
        end
        for (int j = 0; j < NOUT; j++) begin
            pi_ctl_i[j]        = '0;
            pi_ctl_offset_i[j] = '0;
            max_sel_i[j]       = '0;
            bypass_pi_i[j]     = '0;
        end
        adc_sign_i         = '0;
        en_bypass_pi_i     = '0;
        slice_thresh_i     = '0;
        sel_src_i          = SRC_BIST;
        prbs_gen_cke_i     = 1'b1;
        prbs_gen_init_i    = 32'h0000_0001;
        prbs_gen_eqn_i     = eqn;
        prbs_gen_inj_err_i = 1'b0;
        prbs_cke_i         = 1'b1;
        prbs_eqn_i         = eqn;
        prbs_chan_sel_i    = '0;
        prbs_inv_i         = '0;
        prbs_mode_i        = CHK_RESET;
        rst_i              = 1'b1;
        repeat (10) next_cycle();
        rst_i = 1'b0;
        repeat (20) next_cycle();

        // random unfold, slicing and pi scaling
        sel_src_i = SRC_ADC;
        repeat (200) begin
            drive_random_adc_pi();
            next_cycle();
        end

        // bist loop through the generator
        r = lcg_next();
        prbs_chan_sel_i = r[NTI-1:0] | 16'h0001;
        prbs_inv_i      = '0;
        sel_src_i       = SRC_BIST;
        prbs_gen_cke_i  = 1'b1;
        repeat (2) next_cycle();
        prbs_mode_i = CHK_ALIGN;
        repeat (40) next_cycle();
        prbs_mode_i = CHK_TEST;
        repeat (100) next_cycle();
        prbs_gen_inj_err_i = 1'b1;
        next_cycle();
        prbs_gen_inj_err_i = 1'b0;
        repeat (100) next_cycle();
        prbs_mode_i = CHK_FREEZE;
        repeat (20) next_cycle();
        prbs_mode_i = CHK_TEST;
        repeat (10) next_cycle();

        // adc loop, magnitude 40 against a zero threshold
        for (int k = 0; k < NTI; k++) begin
            adc_mag_i[k]    = 8'd40;
            pfd_offset_i[k] = '0;
        end
        r = lcg_next();
        sel_src_i       = SRC_ADC;
        slice_thresh_i  = '0;
        prbs_inv_i      = r[NTI-1:0];
        prbs_chan_sel_i = prbs_chan_sel_i | 16'h0008;
        prbs_mode_i     = CHK_RESET;
        repeat (2) begin
            drive_adc_pattern(-1);
            next_cycle();
        end
        prbs_mode_i = CHK_ALIGN;
        repeat (40) begin
            drive_adc_pattern(-1);
            next_cycle();
        end
        prbs_mode_i = CHK_TEST;
        repeat (100) begin
            drive_adc_pattern(-1);
            next_cycle();
        end
        drive_adc_pattern(3);
        next_cycle();
        repeat (50) begin
            drive_adc_pattern(-1);
            next_cycle();
        end

        if (u_rx_core.u_checker.fail_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- test/rx_core_checker.sv
module rx_core_checker (
    input logic                                    clk_adc,
    input logic                                    rst_i,
    input logic [rx_pkg::NADC-1:0]                 adc_mag_i [rx_pkg::NTI],
    input logic [rx_pkg::NTI-1:0]                  adc_sign_i,
    input logic signed [rx_pkg::NADC-1:0]          pfd_offset_i [rx_pkg::NTI],
    input logic [rx_pkg::NPI-1:0]                  pi_ctl_i [rx_pkg::NOUT],
    input logic [rx_pkg::NPI-1:0]                  pi_ctl_offset_i [rx_pkg::NOUT],
    input logic [rx_pkg::MAX_SEL_W-1:0]            max_sel_i [rx_pkg::NOUT],
    input logic [rx_pkg::NOUT-1:0]                 en_bypass_pi_i,
    input logic [rx_pkg::NPI-1:0]                  bypass_pi_i [rx_pkg::NOUT],
    input logic signed [rx_pkg::NADC-1:0]          slice_thresh_i,
    input rx_pkg::rx_src_e                         sel_src_i,
    input logic                                    prbs_gen_cke_i,
    input logic [rx_pkg::NPRBS-1:0]                prbs_gen_init_i,
    input logic [rx_pkg::NPRBS-1:0]                prbs_gen_eqn_i,
    input logic                                    prbs_gen_inj_err_i,
    input logic                                    prbs_cke_i,
    input logic [rx_pkg::NPRBS-1:0]                prbs_eqn_i,
    input logic [rx_pkg::NTI-1:0]                  prbs_chan_sel_i,
    input logic [rx_pkg::NTI-1:0]                  prbs_inv_i,
    input rx_pkg::chk_mode_e                       prbs_mode_i,
    input logic signed [rx_pkg::NADC-1:0]          adc_code_o [rx_pkg::NTI],
    input logic [rx_pkg::NPI-1:0]                  pi_ctl_o [rx_pkg::NOUT],
    input logic [rx_pkg::CNT_W-1:0]                prbs_err_bits_o,
    input logic [rx_pkg::CNT_W-1:0]                prbs_total_bits_o,
    // internal nets of the core
    input logic [rx_pkg::NTI-1:0]                  rx_bits,
    input logic                                    bist_bit
);

    timeunit 1ns;
    timeprecision 100ps;

    import rx_pkg::*;

    logic signed [NADC-1:0] exp_code [NTI];
    logic [NPI-1:0]         exp_pi [NOUT];
    logic [NTI-1:0]         exp_bits;
    logic [NPRBS-1:0]       gen_state;
    logic                   exp_bist;
    logic [NPRBS-1:0]       mhist [NTI];
    logic [CNT_W-1:0]       exp_err;
    logic [CNT_W-1:0]       exp_total;
    logic                   rst_q;
    logic                   frz_q;
    logic [CNT_W-1:0]       err_q;
    logic [CNT_W-1:0]       total_q;
    int                     fail_cnt = 0;

    function automatic logic [NADC-1:0] unfold_ref(input logic [NADC-1:0] mag,
                                                   input logic sgn,
                                                   input logic signed [NADC-1:0] off);
        int v;
        v = sgn ? int'(mag) : -int'(mag);
        v = v - int'(off);
        return v[NADC-1:0];
    endfunction

    function automatic logic [NPI-1:0] scale_ref(input logic [NPI-1:0] ctl,
                                                 input logic [NPI-1:0] off,
                                                 input logic [MAX_SEL_W-1:0] sel);
        int s;
        int w;
        int p;
        s = (int'(sel) + 1) * 16 - 1;
        w = (int'(ctl) + int'(off)) % (1 << NPI);
        p = (w * s) >> NPI;
        return p[NPI-1:0];
    endfunction

    function automatic logic parity_of(input logic [NPRBS-1:0] v);
        int n;
        n = 0;
        for (int i = 0; i < NPRBS; i++) begin
            n = n + int'(v[i]);
        end
        return n[0];
    endfunction

    always_ff @(posedge clk_adc) begin
        int  ne;
        int  ns;
        logic b;
        ne = 0;
        ns = 0;
        rst_q   <= rst_i;
        err_q   <= prbs_err_bits_o;
        total_q <= prbs_total_bits_o;
        if (rst_i) begin
            for (int k = 0; k < NTI; k++) begin
                exp_code[k] <= '0;
                mhist[k]    <= '0;
            end
            for (int j = 0; j < NOUT; j++) begin
                exp_pi[j] <= '0;
            end
            exp_bits  <= '0;
            gen_state <= prbs_gen_init_i;
            exp_bist  <= 1'b0;
            exp_err   <= '0;
            exp_total <= '0;
            frz_q     <= 1'b0;
        end else begin
            frz_q <= prbs_cke_i && (prbs_mode_i == CHK_FREEZE);
            for (int k = 0; k < NTI; k++) begin
                exp_code[k] <= unfold_ref(adc_mag_i[k], adc_sign_i[k], pfd_offset_i[k]);
                if (sel_src_i == SRC_BIST) begin
                    exp_bits[k] <= bist_bit;
                end else begin
                    exp_bits[k] <= int'(adc_code_o[k]) > int'(slice_thresh_i);
                end
            end
            for (int j = 0; j < NOUT; j++) begin
                exp_pi[j] <= en_bypass_pi_i[j] ? bypass_pi_i[j]
                           : scale_ref(pi_ctl_i[j], pi_ctl_offset_i[j], max_sel_i[j]);
            end
            if (prbs_gen_cke_i) begin
                b = parity_of(gen_state & prbs_gen_eqn_i);
                gen_state <= {gen_state[NPRBS-2:0], b};
                exp_bist  <= b ^ prbs_gen_inj_err_i;
            end
            if (prbs_cke_i && prbs_mode_i == CHK_RESET) begin
                exp_err   <= '0;
                exp_total <= '0;
                for (int k = 0; k < NTI; k++) begin
                    mhist[k] <= '0;
                end
            end else if (prbs_cke_i && prbs_mode_i != CHK_FREEZE) begin
                for (int k = 0; k < NTI; k++) begin
                    b = rx_bits[k] ^ prbs_inv_i[k];
                    mhist[k] <= {mhist[k][NPRBS-2:0], b};
                    if (prbs_chan_sel_i[k]) begin
                        ns = ns + 1;
                        ne = ne + int'(b != parity_of(mhist[k] & prbs_eqn_i));
                    end
                end
                if (prbs_mode_i == CHK_TEST) begin
                    exp_err   <= exp_err + CNT_W'(ne);
                    exp_total <= exp_total + CNT_W'(ns);
                end
            end
        end
    end

    for (genvar k = 0; k < NTI; k++) begin : g_code
        a_code: assert property (@(posedge clk_adc) disable iff (rst_i)
            adc_code_o[k] == exp_code[k])
        else begin
            fail_cnt++;
            $error("ERROR %0t adc_code_o[%0d] expected %0h actual %0h",
                   $time, k, exp_code[k], adc_code_o[k]);
        end
    end

    for (genvar j = 0; j < NOUT; j++) begin : g_pi
        a_pi: assert property (@(posedge clk_adc) disable iff (rst_i)
            pi_ctl_o[j] == exp_pi[j])
        else begin
            fail_cnt++;
            $error("ERROR %0t pi_ctl_o[%0d] expected %0h actual %0h",
                   $time, j, exp_pi[j], pi_ctl_o[j]);
        end
    end

    a_bits: assert property (@(posedge clk_adc) disable iff (rst_i) rx_bits == exp_bits)
    else begin
        fail_cnt++;
        $error("ERROR %0t rx_bits expected %h actual %h", $time, exp_bits, rx_bits);
    end

    a_bist: assert property (@(posedge clk_adc) disable iff (rst_i) bist_bit == exp_bist)
    else begin
        fail_cnt++;
        $error("ERROR %0t bist_bit expected %b actual %b", $time, exp_bist, bist_bit);
    end

    a_err: assert property (@(posedge clk_adc) disable iff (rst_i)
        prbs_err_bits_o == exp_err && prbs_total_bits_o == exp_total)
    else begin
        fail_cnt++;
        $error("ERROR %0t prbs_err_bits_o/prbs_total_bits_o expected %0d/%0d actual %0d/%0d",
               $time, exp_err, exp_total, prbs_err_bits_o, prbs_total_bits_o);
    end

    // outputs come out of reset at zero
    a_reset: assert property (@(posedge clk_adc) rst_q && !rst_i |->
        prbs_err_bits_o == '0 && prbs_total_bits_o == '0 && rx_bits == '0
        && adc_code_o[0] == '0 && pi_ctl_o[0] == '0)
    else begin
        fail_cnt++;
        $error("outputs were not zero right after reset");
    end

    a_freeze: assert property (@(posedge clk_adc) disable iff (rst_i)
        frz_q |-> prbs_err_bits_o == err_q && prbs_total_bits_o == total_q)
    else begin
        fail_cnt++;
        $error("ERROR %0t prbs_err_bits_o/prbs_total_bits_o held %0d/%0d actual %0d/%0d",
               $time, err_q, total_q, prbs_err_bits_o, prbs_total_bits_o);
    end

endmodule

//--- source/rx_core.sv
module rx_core #(
    parameter int nti   = rx_pkg::NTI,
    parameter int nadc  = rx_pkg::NADC,
    parameter int npi   = rx_pkg::NPI,
    parameter int nout  = rx_pkg::NOUT,
    parameter int nprbs = rx_pkg::NPRBS
) (
    input  logic                         clk_adc,
    input  logic                         rst_i,
    // adc slices
    input  logic [nadc-1:0]              adc_mag_i [nti],
    input  logic [nti-1:0]               adc_sign_i,
    input  logic signed [nadc-1:0]       pfd_offset_i [nti],
    // phase interpolator control
    input  logic [npi-1:0]               pi_ctl_i [nout],
    input  logic [npi-1:0]               pi_ctl_offset_i [nout],
    input  logic [rx_pkg::MAX_SEL_W-1:0] max_sel_i [nout],
    input  logic [nout-1:0]              en_bypass_pi_i,
    input  logic [npi-1:0]               bypass_pi_i [nout],
    // slicer and source select
    input  logic signed [nadc-1:0]       slice_thresh_i,
    input  rx_pkg::rx_src_e              sel_src_i,
    // bist generator
    input  logic                         prbs_gen_cke_i,
    input  logic [nprbs-1:0]             prbs_gen_init_i,
    input  logic [nprbs-1:0]             prbs_gen_eqn_i,
    input  logic                         prbs_gen_inj_err_i,
    // prbs checker
    input  logic                         prbs_cke_i,
    input  logic [nprbs-1:0]             prbs_eqn_i,
    input  logic [nti-1:0]               prbs_chan_sel_i,
    input  logic [nti-1:0]               prbs_inv_i,
    input  rx_pkg::chk_mode_e            prbs_mode_i,
    output logic signed [nadc-1:0]       adc_code_o [nti],
    output logic [npi-1:0]               pi_ctl_o [nout],
    output logic [rx_pkg::CNT_W-1:0]     prbs_err_bits_o,
    output logic [rx_pkg::CNT_W-1:0]     prbs_total_bits_o
);

    logic [nti-1:0] rx_bits;
    logic           bist_bit;

    // unfolded codes leave the core and feed the slicer
    adc_unfold #(.nti(nti), .nadc(nadc)) u_adc_unfold (
        .clk_adc      (clk_adc),
        .rst_i        (rst_i),
        .adc_mag_i    (adc_mag_i),
        .adc_sign_i   (adc_sign_i),
        .pfd_offset_i (pfd_offset_i),
        .code_o       (adc_code_o)
    );

    bit_slicer #(.nti(nti), .nadc(nadc)) u_bit_slicer (
        .clk_adc    (clk_adc),
        .rst_i      (rst_i),
        .code_i     (adc_code_o),
        .thresh_i   (slice_thresh_i),
        .bist_bit_i (bist_bit),
        .sel_src_i  (sel_src_i),
        .rx_bits_o  (rx_bits)
    );

    prbs_generator #(.nprbs(nprbs)) u_prbs_generator (
        .clk_adc   (clk_adc),
        .rst_i     (rst_i),
        .cke_i     (prbs_gen_cke_i),
        .init_i    (prbs_gen_init_i),
        .eqn_i     (prbs_gen_eqn_i),
        .inj_err_i (prbs_gen_inj_err_i),
        .bit_o     (bist_bit)
    );

    prbs_checker #(.nti(nti), .nprbs(nprbs)) u_prbs_checker (
        .clk_adc      (clk_adc),
        .rst_i        (rst_i),
        .cke_i        (prbs_cke_i),
        .eqn_i        (prbs_eqn_i),
        .chan_sel_i   (prbs_chan_sel_i),
        .inv_i        (prbs_inv_i),
        .rx_bits_i    (rx_bits),
        .mode_i       (prbs_mode_i),
        .err_bits_o   (prbs_err_bits_o),
        .total_bits_o (prbs_total_bits_o)
    );

    // pi path is independent of the data path
    pi_ctl_scaler #(.nout(nout), .npi(npi)) u_pi_ctl_scaler (
        .clk_adc         (clk_adc),
        .rst_i           (rst_i),
        .pi_ctl_i        (pi_ctl_i),
        .pi_ctl_offset_i (pi_ctl_offset_i),
        .max_sel_i       (max_sel_i),
        .en_bypass_pi_i  (en_bypass_pi_i),
        .bypass_pi_i     (bypass_pi_i),
        .pi_ctl_o        (pi_ctl_o)
    );

endmodule

//--- source/prbs_checker.sv
module prbs_checker #(
    parameter int nti   = rx_pkg::NTI,
    parameter int nprbs = rx_pkg::NPRBS
) (
    input  logic                     clk_adc,
    input  logic                     rst_i,
    // advance enable
    input  logic                     cke_i,
    // feedback taps, same as the transmitter
    input  logic [nprbs-1:0]         eqn_i,
    // slices that take part in counting
    input  logic [nti-1:0]           chan_sel_i,
    // per-slice polarity flip
    input  logic [nti-1:0]           inv_i,
    input  logic [nti-1:0]           rx_bits_i,
    input  rx_pkg::chk_mode_e        mode_i,
    output logic [rx_pkg::CNT_W-1:0] err_bits_o,
    output logic [rx_pkg::CNT_W-1:0] total_bits_o
);

    import rx_pkg::*;

    localparam int cw = $clog2(nti + 1);

    logic [nprbs-1:0] hist [nti];
    logic [nti-1:0]   rx_corr;
    logic [nti-1:0]   predicted;
    logic [nti-1:0]   err_vec;
    logic [cw-1:0]    n_err;
    logic [cw-1:0]    n_sel;

    assign rx_corr = rx_bits_i ^ inv_i;

    // each slice predicts from its own history
    always_comb begin
        for (int k = 0; k < nti; k++) begin
            predicted[k] = ^(hist[k] & eqn_i);
        end
    end

    assign err_vec = rx_corr ^ predicted;

    // popcounts over the selected slices
    always_comb begin
        n_err = '0;
        n_sel = '0;
        for (int k = 0; k < nti; k++) begin
            if (chan_sel_i[k]) begin
                n_sel = n_sel + 1'b1;
                if (err_vec[k]) begin
                    n_err = n_err + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            err_bits_o   <= '0;
            total_bits_o <= '0;
            for (int k = 0; k < nti; k++) begin
                hist[k] <= '0;
            end
        end else if (cke_i) begin
            case (mode_i)
                CHK_RESET: begin
                    err_bits_o   <= '0;
                    total_bits_o <= '0;
                    for (int k = 0; k < nti; k++) begin
                        hist[k] <= '0;
                    end
                end
                CHK_ALIGN: begin
                    for (int k = 0; k < nti; k++) begin
                        hist[k] <= {hist[k][nprbs-2:0], rx_corr[k]};
                    end
                end
                CHK_TEST: begin
                    // received bit goes into history even when wrong
                    for (int k = 0; k < nti; k++) begin
                        hist[k] <= {hist[k][nprbs-2:0], rx_corr[k]};
                    end
                    err_bits_o   <= err_bits_o + CNT_W'(n_err);
                    total_bits_o <= total_bits_o + CNT_W'(n_sel);
                end
                CHK_FREEZE: begin
                    // everything holds
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- source/prbs_generator.sv
module prbs_generator #(
    parameter int nprbs = rx_pkg::NPRBS
) (
    input  logic             clk_adc,
    input  logic             rst_i,
    // advance enable
    input  logic             cke_i,
    // state loaded while in reset
    input  logic [nprbs-1:0] init_i,
    // feedback taps
    input  logic [nprbs-1:0] eqn_i,
    // flips the outgoing bit only
    input  logic             inj_err_i,
    output logic             bit_o
);

    logic [nprbs-1:0] state;
    logic             feedback;

    // parity of the tapped state bits
    assign feedback = ^(state & eqn_i);

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            state <= init_i;
        end else if (cke_i) begin
            // new bit enters at the low end
            state <= {state[nprbs-2:0], feedback};
        end
    end

    // injected error never touches the lfsr state,
    // so the pattern resumes cleanly on the next bit
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            bit_o <= 1'b0;
        end else if (cke_i) begin
            bit_o <= feedback ^ inj_err_i;
        end
    end

endmodule

//--- source/bit_slicer.sv
module bit_slicer #(
    parameter int nti  = rx_pkg::NTI,
    parameter int nadc = rx_pkg::NADC
) (
    input  logic                   clk_adc,
    input  logic                   rst_i,
    // unfolded codes, one per slice
    input  logic signed [nadc-1:0] code_i [nti],
    input  logic signed [nadc-1:0] thresh_i,
    // serial bist bit from the generator
    input  logic                   bist_bit_i,
    input  rx_pkg::rx_src_e        sel_src_i,
    output logic [nti-1:0]         rx_bits_o
);

    import rx_pkg::*;

    logic [nti-1:0] adc_bits;
    logic [nti-1:0] next_bits;

    // decision per slice, strictly above threshold is a one
    always_comb begin
        for (int k = 0; k < nti; k++) begin
            adc_bits[k] = (code_i[k] > thresh_i);
        end
    end

    // bist bit fans out to every slice
    always_comb begin
        case (sel_src_i)
            SRC_ADC:  next_bits = adc_bits;
            SRC_BIST: next_bits = {nti{bist_bit_i}};
            default:  next_bits = adc_bits;
        endcase
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            rx_bits_o <= '0;
        end else begin
            rx_bits_o <= next_bits;
        end
    end

endmodule

//--- source/pi_ctl_scaler.sv
module pi_ctl_scaler #(
    parameter int nout = rx_pkg::NOUT,
    parameter int npi  = rx_pkg::NPI
) (
    input  logic                         clk_adc,
    input  logic                         rst_i,
    // control words from the loop, one per pi output
    input  logic [npi-1:0]               pi_ctl_i [nout],
    input  logic [npi-1:0]               pi_ctl_offset_i [nout],
    // range select per output
    input  logic [rx_pkg::MAX_SEL_W-1:0] max_sel_i [nout],
    // direct override of the control word
    input  logic [nout-1:0]              en_bypass_pi_i,
    input  logic [npi-1:0]               bypass_pi_i [nout],
    output logic [npi-1:0]               pi_ctl_o [nout]
);

    logic [npi:0]       sel_steps [nout];
    logic [npi-1:0]     scale [nout];
    logic [npi-1:0]     shifted [nout];
    logic [2*npi-1:0]   product [nout];
    logic [npi-1:0]     next_ctl [nout];

    always_comb begin
        for (int j = 0; j < nout; j++) begin
            // scale = (sel + 1) * 16 - 1, one spare bit for sel at max
            sel_steps[j] = (npi + 1)'(max_sel_i[j]) + 1'b1;
            scale[j]     = npi'((sel_steps[j] << 4) - 1'b1);
            // offset wraps at npi bits before scaling
            shifted[j]   = pi_ctl_i[j] + pi_ctl_offset_i[j];
            product[j]   = (2*npi)'(shifted[j]) * (2*npi)'(scale[j]);
            if (en_bypass_pi_i[j]) begin
                next_ctl[j] = bypass_pi_i[j];
            end else begin
                next_ctl[j] = product[j][2*npi-1:npi];
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            for (int j = 0; j < nout; j++) begin
                pi_ctl_o[j] <= '0;
            end
        end else begin
            for (int j = 0; j < nout; j++) begin
                pi_ctl_o[j] <= next_ctl[j];
            end
        end
    end

endmodule

//--- source/adc_unfold.sv
module adc_unfold #(
    parameter int nti  = rx_pkg::NTI,
    parameter int nadc = rx_pkg::NADC
) (
    input  logic                   clk_adc,
    input  logic                   rst_i,
    // per-slice magnitude and sign from the adc
    input  logic [nadc-1:0]        adc_mag_i [nti],
    input  logic [nti-1:0]         adc_sign_i,
    // per-slice pfd offset to remove
    input  logic signed [nadc-1:0] pfd_offset_i [nti],
    output logic signed [nadc-1:0] code_o [nti]
);

    logic signed [nadc-1:0] folded [nti];
    logic signed [nadc-1:0] corrected [nti];

    for (genvar k = 0; k < nti; k++) begin : g_slice

        // sign high means a positive sample
        assign folded[k] = adc_sign_i[k] ? $signed(adc_mag_i[k])
                                         : -$signed(adc_mag_i[k]);

        // wraps to nadc bits
        assign corrected[k] = folded[k] - pfd_offset_i[k];

        always_ff @(posedge clk_adc) begin
            if (rst_i) begin
                code_o[k] <= '0;
            end else begin
                code_o[k] <= corrected[k];
            end
        end

    end

endmodule

//--- source/rx_pkg.sv
package rx_pkg;

    // interleaved adc slices per parallel word
    localparam int NTI = 16;

    // adc code width
    localparam int NADC = 8;

    // phase interpolator control word width
    localparam int NPI = 9;

    // number of phase interpolator outputs
    localparam int NOUT = 4;

    // per-output range select, scale is (sel + 1) * 16 - 1
    localparam int MAX_SEL_W = 5;

    // lfsr length shared by generator and checker
    localparam int NPRBS = 32;

    // error and total bit counters
    localparam int CNT_W = 64;

    // bit source feeding the prbs checker
    typedef enum logic {
        SRC_ADC  = 1'b0,
        SRC_BIST = 1'b1
    } rx_src_e;

    // prbs checker operation
    typedef enum logic [1:0] {
        // clear counters and history
        CHK_RESET  = 2'd0,
        // fill history, no counting
        CHK_ALIGN  = 2'd1,
        // compare and count
        CHK_TEST   = 2'd2,
        // hold counters and history
        CHK_FREEZE = 2'd3
    } chk_mode_e;

endpackage
